// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

	typedef logic [15:0] word_t;        // Registers, stack data, output
	typedef logic [31:0] instr_t;       // {opcode, a, b, c}
	typedef logic [7:0] field_t;
	typedef logic [3:0] reg_index_t;
	typedef logic [7:0] imem_addr_t;
	typedef logic [15:0] stack_addr_t;  // Same width as the stack pointer

	localparam int NUM_REGS = 16;
	localparam int IMEM_DEPTH = 256;
	localparam int STACK_DEPTH = 2048;

	// Highest legal stack address
	localparam stack_addr_t STACK_LIMIT = 16'd2047;

	// Values not listed here are unknown opcodes
	typedef enum logic [7:0] {
		OP_EOF = 8'd0,
		OP_LOAD = 8'd1,     // R[c] = stack[sp - {a,b}]
		OP_STORE = 8'd2,    // stack[sp - {b,c}] = R[a]
		OP_LITERAL = 8'd3,  // R[c] = {a,b}
		OP_OUTPUT = 8'd5,
		OP_ADD = 8'd6,
		OP_SUB = 8'd7,
		OP_MUL = 8'd8,
		OP_BRANCH = 8'd11,  // Skip next if R[a] is zero
		OP_JUMP = 8'd12,
		OP_STACK = 8'd13,
		OP_INC = 8'd23,
		OP_DEC = 8'd24,
		OP_MOV = 8'd25,     // R[b] = R[a]
		OP_NOT = 8'd26,
		OP_OR = 8'd27,
		OP_AND = 8'd28,
		OP_EQ = 8'd29,
		OP_LT = 8'd30,
		OP_GT = 8'd31
	} opcode_t;

endpackage

// ==== verilog/instruction_memory.sv ====
module instruction_memory (
	input logic clock,
	input logic load_write,
	input cpu_pkg::imem_addr_t load_address,
	input cpu_pkg::instr_t load_data,
	input cpu_pkg::imem_addr_t fetch_address,
	output cpu_pkg::instr_t instruction
);

	cpu_pkg::instr_t memory [cpu_pkg::IMEM_DEPTH];

	// Program load port
	always_ff @(posedge clock) begin
		if (load_write) begin
			memory[load_address] <= load_data;
		end
	end

	always_ff @(posedge clock) begin
		instruction <= memory[fetch_address];  // One cycle read
	end

endmodule

// ==== verilog/register_file.sv ====
module register_file (
	input logic clock,
	input cpu_pkg::instr_t instruction,
	input logic write_enable,
	input cpu_pkg::reg_index_t write_index,
	input cpu_pkg::word_t write_data,
	output cpu_pkg::word_t read_a,
	output cpu_pkg::word_t read_b,
	output cpu_pkg::word_t read_c
);

	cpu_pkg::word_t registers [cpu_pkg::NUM_REGS];
	cpu_pkg::reg_index_t index_a;
	cpu_pkg::reg_index_t index_b;
	cpu_pkg::reg_index_t index_c;

	// Low nibble of each operand field
	assign index_a = instruction[19:16];
	assign index_b = instruction[11:8];
	assign index_c = instruction[3:0];

	always_ff @(posedge clock) begin
		if (write_enable) begin
			registers[write_index] <= write_data;
		end
	end

	assign read_a = registers[index_a];
	assign read_b = registers[index_b];
	assign read_c = registers[index_c];

endmodule

// ==== verilog/alu.sv ====
module alu (
	input cpu_pkg::instr_t instruction,
	input cpu_pkg::word_t operand_a,
	input cpu_pkg::word_t operand_b,
	output cpu_pkg::word_t result
);

	cpu_pkg::opcode_t opcode;
	cpu_pkg::field_t field_a;
	cpu_pkg::field_t field_b;

	assign opcode = cpu_pkg::opcode_t'(instruction[31:24]);
	assign field_a = instruction[23:16];
	assign field_b = instruction[15:8];

	always_comb begin
		result = '0;
		case (opcode)
			cpu_pkg::OP_LITERAL: result = {field_a, field_b};
			cpu_pkg::OP_ADD: result = operand_a + operand_b;
			cpu_pkg::OP_SUB: result = operand_a - operand_b;
			cpu_pkg::OP_MUL: result = $signed(operand_a) * $signed(operand_b);  // Low half only
			cpu_pkg::OP_INC: result = operand_a + 16'd1;
			cpu_pkg::OP_DEC: result = operand_a - 16'd1;
			cpu_pkg::OP_MOV: result = operand_a;
			cpu_pkg::OP_NOT: result = cpu_pkg::word_t'(operand_a == '0);
			// Logical, not bitwise
			cpu_pkg::OP_OR: begin
				result = cpu_pkg::word_t'((operand_a != '0) || (operand_b != '0));
			end
			cpu_pkg::OP_AND: begin
				result = cpu_pkg::word_t'((operand_a != '0) && (operand_b != '0));
			end
			cpu_pkg::OP_EQ: result = cpu_pkg::word_t'(operand_a == operand_b);
			cpu_pkg::OP_LT: begin
				result = cpu_pkg::word_t'($signed(operand_a) < $signed(operand_b));
			end
			cpu_pkg::OP_GT: begin
				result = cpu_pkg::word_t'($signed(operand_a) > $signed(operand_b));
			end
			default: result = '0;
		endcase
	end

endmodule

// ==== verilog/stack_memory.sv ====
module stack_memory (
	input logic clock,
	input cpu_pkg::stack_addr_t stack_address,
	input logic stack_read,
	input logic stack_write,
	input cpu_pkg::word_t stack_write_data,
	output cpu_pkg::word_t stack_read_data,
	output logic stack_fault
);

	cpu_pkg::word_t memory [cpu_pkg::STACK_DEPTH];
	logic [$clog2(cpu_pkg::STACK_DEPTH)-1:0] stack_index;
	logic out_of_range;

	assign stack_index = stack_address[$bits(stack_index)-1:0];
	assign out_of_range = stack_address > cpu_pkg::STACK_LIMIT;

	// Only flagged on an actual access
	assign stack_fault = (stack_read || stack_write) && out_of_range;

	always_ff @(posedge clock) begin
		if (stack_write && !out_of_range) begin
			memory[stack_index] <= stack_write_data;
		end
	end

	always_ff @(posedge clock) begin
		if (stack_read && !out_of_range) begin
			stack_read_data <= memory[stack_index];
		end
	end

endmodule

// ==== verilog/cpu_control.sv ====
module cpu_control (
	input logic clock,
	input logic reset_n,
	input logic start,
	input cpu_pkg::instr_t instruction,
	input cpu_pkg::word_t read_a,
	input cpu_pkg::word_t read_b,
	input cpu_pkg::word_t alu_result,
	input cpu_pkg::word_t stack_read_data,
	input logic stack_fault,
	output cpu_pkg::imem_addr_t fetch_address,
	output logic write_enable,
	output cpu_pkg::reg_index_t write_index,
	output cpu_pkg::word_t write_data,
	output cpu_pkg::stack_addr_t stack_address,
	output logic stack_read,
	output logic stack_write,
	output cpu_pkg::word_t stack_write_data,
	output logic out_valid,
	output cpu_pkg::word_t out_value,
	output logic running,
	output logic done,
	output logic unknown_opcode,
	output logic stack_fault_flag
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FETCH,
		ST_WAIT,
		ST_EXECUTE,
		ST_LOAD_WAIT,
		ST_HALTED
	} state_t;

	state_t state;
	cpu_pkg::imem_addr_t pc;
	cpu_pkg::stack_addr_t sp;
	cpu_pkg::opcode_t opcode;
	cpu_pkg::field_t field_a;
	cpu_pkg::field_t field_b;
	cpu_pkg::field_t field_c;
	logic exec_write;
	logic error;

	assign opcode = cpu_pkg::opcode_t'(instruction[31:24]);
	assign field_a = instruction[23:16];
	assign field_b = instruction[15:8];
	assign field_c = instruction[7:0];

	assign error = unknown_opcode || stack_fault_flag;
	assign running = (state != ST_IDLE) && (state != ST_HALTED);
	assign fetch_address = pc;

	// Destination register per opcode
	always_comb begin
		exec_write = 1'b0;
		write_index = field_c[3:0];
		case (opcode)
			cpu_pkg::OP_LITERAL, cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_MUL,
			cpu_pkg::OP_OR, cpu_pkg::OP_AND, cpu_pkg::OP_EQ, cpu_pkg::OP_LT,
			cpu_pkg::OP_GT: begin
				exec_write = 1'b1;
			end
			cpu_pkg::OP_INC, cpu_pkg::OP_DEC: begin
				exec_write = 1'b1;
				write_index = field_a[3:0];
			end
			cpu_pkg::OP_MOV, cpu_pkg::OP_NOT: begin
				exec_write = 1'b1;
				write_index = field_b[3:0];
			end
			default: exec_write = 1'b0;
		endcase
	end

	// LOAD result lands one cycle after the read strobe
	assign write_enable = ((state == ST_EXECUTE) && exec_write) || (state == ST_LOAD_WAIT);
	assign write_data = (state == ST_LOAD_WAIT) ? stack_read_data : alu_result;

	// STORE offset is {b,c}, LOAD offset is {a,b}
	assign stack_address = (opcode == cpu_pkg::OP_STORE) ? sp - {field_b, field_c}
		: sp - {field_a, field_b};
	assign stack_read = (state == ST_EXECUTE) && (opcode == cpu_pkg::OP_LOAD);
	assign stack_write = (state == ST_EXECUTE) && (opcode == cpu_pkg::OP_STORE);
	assign stack_write_data = read_a;

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			state <= ST_IDLE;
			pc <= '0;
			sp <= '0;
			out_valid <= 1'b0;
			out_value <= '0;
			done <= 1'b0;
			unknown_opcode <= 1'b0;
			stack_fault_flag <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start && !error) begin
						pc <= '0;
						state <= ST_FETCH;
					end
				end
				ST_FETCH: state <= ST_WAIT;
				ST_WAIT: state <= ST_EXECUTE;  // Instruction valid from here
				ST_EXECUTE: begin
					pc <= pc + 8'd1;
					state <= ST_FETCH;
					case (opcode)
						cpu_pkg::OP_EOF: begin
							done <= 1'b1;
							state <= ST_HALTED;
						end
						cpu_pkg::OP_OUTPUT: begin
							out_valid <= 1'b1;
							out_value <= read_a;
						end
						cpu_pkg::OP_BRANCH: begin
							if (read_a == '0) begin
								pc <= pc + 8'd2;
							end
						end
						cpu_pkg::OP_JUMP: begin
							if (field_a == '0) begin
								pc <= cpu_pkg::imem_addr_t'({field_b, field_c});
							end else begin
								pc <= cpu_pkg::imem_addr_t'(read_b);
							end
						end
						cpu_pkg::OP_STACK: sp <= sp + {field_a, field_b};
						cpu_pkg::OP_STORE: begin
							if (stack_fault) begin
								stack_fault_flag <= 1'b1;
								state <= ST_HALTED;
							end
						end
						cpu_pkg::OP_LOAD: begin
							pc <= pc;  // Advanced after the read returns
							if (stack_fault) begin
								stack_fault_flag <= 1'b1;
								state <= ST_HALTED;
							end else begin
								state <= ST_LOAD_WAIT;
							end
						end
						default: begin
							if (!exec_write) begin
								unknown_opcode <= 1'b1;
								state <= ST_HALTED;
							end
						end
					endcase
				end
				ST_LOAD_WAIT: begin
					pc <= pc + 8'd1;
					state <= ST_FETCH;
				end
				ST_HALTED: state <= ST_HALTED;  // Left only by reset
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== verilog/playground_cpu.sv ====
module playground_cpu (
	input logic clock,
	input logic reset_n,
	input logic load_write,
	input cpu_pkg::imem_addr_t load_address,
	input cpu_pkg::instr_t load_data,
	input logic start,
	output logic out_valid,
	output cpu_pkg::word_t out_value,
	output logic running,
	output logic done,
	output logic unknown_opcode,
	output logic stack_fault,
	output logic error
);

	cpu_pkg::imem_addr_t fetch_address;
	cpu_pkg::instr_t instruction;
	cpu_pkg::word_t read_a;
	cpu_pkg::word_t read_b;
	cpu_pkg::word_t alu_result;
	logic write_enable;
	cpu_pkg::reg_index_t write_index;
	cpu_pkg::word_t write_data;
	cpu_pkg::stack_addr_t stack_address;
	logic stack_read;
	logic stack_write;
	cpu_pkg::word_t stack_write_data;
	cpu_pkg::word_t stack_read_data;
	logic mem_stack_fault;  // Raw, per access

	assign error = unknown_opcode | stack_fault;

	instruction_memory instruction_memory_inst (
		.clock(clock),
		.load_write(load_write),
		.load_address(load_address),
		.load_data(load_data),
		.fetch_address(fetch_address),
		.instruction(instruction)
	);

	register_file register_file_inst (
		.clock(clock),
		.instruction(instruction),
		.write_enable(write_enable),
		.write_index(write_index),
		.write_data(write_data),
		.read_a(read_a),
		.read_b(read_b),
		.read_c()
	);

	alu alu_inst (
		.instruction(instruction),
		.operand_a(read_a),
		.operand_b(read_b),
		.result(alu_result)
	);

	stack_memory stack_memory_inst (
		.clock(clock),
		.stack_address(stack_address),
		.stack_read(stack_read),
		.stack_write(stack_write),
		.stack_write_data(stack_write_data),
		.stack_read_data(stack_read_data),
		.stack_fault(mem_stack_fault)
	);

	cpu_control cpu_control_inst (
		.clock(clock),
		.reset_n(reset_n),
		.start(start),
		.instruction(instruction),
		.read_a(read_a),
		.read_b(read_b),
		.alu_result(alu_result),
		.stack_read_data(stack_read_data),
		.stack_fault(mem_stack_fault),
		.fetch_address(fetch_address),
		.write_enable(write_enable),
		.write_index(write_index),
		.write_data(write_data),
		.stack_address(stack_address),
		.stack_read(stack_read),
		.stack_write(stack_write),
		.stack_write_data(stack_write_data),
		.out_valid(out_valid),
		.out_value(out_value),
		.running(running),
		.done(done),
		.unknown_opcode(unknown_opcode),
		.stack_fault_flag(stack_fault)
	);

endmodule

// ==== verif/playground_cpu_chk.sv ====
module playground_cpu_chk (
	input logic clock,
	input logic reset_n,
	input logic running,
	input logic done,
	input logic out_valid,
	input logic unknown_opcode,
	input logic stack_fault_flag
);

	int failures = 0;  // Failed assertion count

	out_valid_running: assert property (@(posedge clock) disable iff (!reset_n)
		out_valid |-> running)
		else begin
			$error("out_valid seen while the CPU is not running");
			failures++;
		end

	done_error_exclusive: assert property (@(posedge clock) disable iff (!reset_n)
		!(done && (unknown_opcode || stack_fault_flag)))
		else begin
			$error("done and an error flag are high together");
			failures++;
		end

	// Sticky until reset
	unknown_sticky: assert property (@(posedge clock) disable iff (!reset_n)
		unknown_opcode |=> unknown_opcode)
		else begin
			$error("unknown_opcode dropped without a reset");
			failures++;
		end

	idle_after_reset: assert property (@(posedge clock) !reset_n |=> !running)
		else begin
			$error("running high in the cycle after reset");
			failures++;
		end

endmodule

// ==== verif/playground_cpu_tb.sv ====
module playground_cpu_tb;

	logic clock;
	logic reset_n;
	logic load_write;
	cpu_pkg::imem_addr_t load_address;
	cpu_pkg::instr_t load_data;
	logic start;
	logic out_valid;
	cpu_pkg::word_t out_value;
	logic running;
	logic done;
	logic unknown_opcode;
	logic stack_fault;
	logic error;

	integer seed = 32'haa502b03;
	cpu_pkg::instr_t prog [cpu_pkg::IMEM_DEPTH];
	int plen;
	cpu_pkg::word_t model_regs [cpu_pkg::NUM_REGS];
	cpu_pkg::word_t model_stack [cpu_pkg::STACK_DEPTH];
	cpu_pkg::word_t exp_out [$];
	cpu_pkg::word_t act_out [$];
	logic exp_done;
	logic exp_unknown;
	logic exp_fault;
	logic [7:0] alu_ops [13] = '{cpu_pkg::OP_LITERAL, cpu_pkg::OP_ADD, cpu_pkg::OP_SUB,
		cpu_pkg::OP_MUL, cpu_pkg::OP_INC, cpu_pkg::OP_DEC, cpu_pkg::OP_MOV, cpu_pkg::OP_NOT,
		cpu_pkg::OP_OR, cpu_pkg::OP_AND, cpu_pkg::OP_EQ, cpu_pkg::OP_LT, cpu_pkg::OP_GT};
	string test_names [5] = '{"arith_logic", "stack", "control_flow", "unknown_opcode",
		"stack_fault"};

	playground_cpu playground_cpu_inst (
		.clock(clock),
		.reset_n(reset_n),
		.load_write(load_write),
		.load_address(load_address),
		.load_data(load_data),
		.start(start),
		.out_valid(out_valid),
		.out_value(out_value),
		.running(running),
		.done(done),
		.unknown_opcode(unknown_opcode),
		.stack_fault(stack_fault),
		.error(error)
	);

	bind cpu_control playground_cpu_chk chk_inst (
		.clock(clock),
		.reset_n(reset_n),
		.running(running),
		.done(done),
		.out_valid(out_valid),
		.unknown_opcode(unknown_opcode),
		.stack_fault_flag(stack_fault_flag)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic int rand_below(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	task automatic stop_on_error(string line);
		$display("%s", line);
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped at first error");
	endtask

	// Bound assertions count their failures
	always @(negedge clock) begin
		if (playground_cpu_inst.cpu_control_inst.chk_inst.failures != 0) begin
			stop_on_error("An assertion on the control module failed");
		end
	end

	task automatic compare_word(string test, string what, cpu_pkg::word_t expected,
		cpu_pkg::word_t actual);
		if (expected !== actual) begin
			stop_on_error($sformatf("MISMATCH %s %s: expected %h actual %h",
				test, what, expected, actual));
		end
	endtask

	task automatic compare_flag(string test, string what, logic expected, logic actual);
		if (expected !== actual) begin
			stop_on_error($sformatf("MISMATCH %s %s: expected %b actual %b",
				test, what, expected, actual));
		end
	endtask

	task automatic emit(logic [7:0] op, cpu_pkg::field_t a, cpu_pkg::field_t b,
		cpu_pkg::field_t c);
		prog[plen] = {op, a, b, c};
		plen++;
	endtask

	task automatic gen_program(int mode);
		cpu_pkg::field_t a;
		cpu_pkg::field_t b;
		cpu_pkg::field_t c;
		int skip;
		int target;
		int off;
		int gen_sp;
		foreach (prog[i]) prog[i] = '0;  // Unused words read as EOF
		plen = 0;
		gen_sp = 0;
		for (int r = 0; r < cpu_pkg::NUM_REGS; r++) begin
			emit(cpu_pkg::OP_LITERAL, cpu_pkg::field_t'(rand_below(256)),
				cpu_pkg::field_t'(rand_below(256)), cpu_pkg::field_t'(r));
		end
		for (int step = 0; step < 12; step++) begin
			a = cpu_pkg::field_t'(rand_below(256));
			b = cpu_pkg::field_t'(rand_below(256));
			c = cpu_pkg::field_t'(rand_below(256));
			if (mode == 3 && step == 6) begin
				emit(cpu_pkg::field_t'(32 + rand_below(200)), a, b, c);
			end else if (mode == 4 && step == 4) begin
				if (rand_below(2) == 1) begin
					emit(cpu_pkg::OP_STORE, a, 8'd0,
						cpu_pkg::field_t'(1 + rand_below(8)));  // sp is 0
				end else begin
					emit(cpu_pkg::OP_STACK, 8'h0b, 8'hb8, 8'd0);  // sp = 3000
					emit(cpu_pkg::OP_LOAD, 8'd0, 8'd0, c);
				end
			end else if (mode == 1) begin
				off = 1 + rand_below(32);
				gen_sp += off;
				emit(cpu_pkg::OP_STACK, 8'd0, cpu_pkg::field_t'(off), 8'd0);
				off = rand_below(gen_sp + 1);
				emit(cpu_pkg::OP_STORE, a, cpu_pkg::field_t'(off >> 8), cpu_pkg::field_t'(off));
				emit(cpu_pkg::OP_LOAD, cpu_pkg::field_t'(off >> 8), cpu_pkg::field_t'(off), c);
				emit(cpu_pkg::OP_OUTPUT, c, 8'd0, 8'd0);
			end else if (mode == 2) begin
				skip = rand_below(3);
				case (rand_below(3))
					0: begin
						if (rand_below(2) == 1) b = '0;
						emit(cpu_pkg::OP_LITERAL, 8'd0, b, a);
						emit(cpu_pkg::OP_BRANCH, a, 8'd0, 8'd0);
						emit(cpu_pkg::OP_OUTPUT, c, 8'd0, 8'd0);  // Skipped when zero
						emit(cpu_pkg::OP_OUTPUT, a, 8'd0, 8'd0);
					end
					1: begin
						target = plen + 1 + skip;
						emit(cpu_pkg::OP_JUMP, 8'd0, 8'd0, cpu_pkg::field_t'(target));
						repeat (skip) emit(cpu_pkg::OP_OUTPUT, b, 8'd0, 8'd0);
					end
					default: begin
						target = plen + 2 + skip;
						emit(cpu_pkg::OP_LITERAL, 8'd0, cpu_pkg::field_t'(target), a);
						emit(cpu_pkg::OP_JUMP, 8'd1, a, 8'd0);  // Target from R[b]
						repeat (skip) emit(cpu_pkg::OP_OUTPUT, b, 8'd0, 8'd0);
						emit(cpu_pkg::OP_OUTPUT, a, 8'd0, 8'd0);
					end
				endcase
			end else begin
				emit(alu_ops[rand_below(13)], a, b, c);
				emit(cpu_pkg::OP_OUTPUT, a, 8'd0, 8'd0);
				emit(cpu_pkg::OP_OUTPUT, b, 8'd0, 8'd0);
				emit(cpu_pkg::OP_OUTPUT, c, 8'd0, 8'd0);
			end
		end
		emit(cpu_pkg::OP_EOF, 8'd0, 8'd0, 8'd0);
	endtask

	// Instruction-level reference model
	task automatic run_model();
		cpu_pkg::imem_addr_t pc;
		cpu_pkg::stack_addr_t sp;
		cpu_pkg::stack_addr_t addr;
		logic [7:0] op;
		cpu_pkg::field_t a;
		cpu_pkg::field_t b;
		cpu_pkg::field_t c;
		cpu_pkg::word_t ra;
		cpu_pkg::word_t rb;
		int steps;
		logic halted;
		pc = '0;
		sp = '0;
		steps = 0;
		halted = 1'b0;
		exp_out.delete();
		exp_done = 1'b0;
		exp_unknown = 1'b0;
		exp_fault = 1'b0;
		while (!halted) begin
			{op, a, b, c} = prog[pc];
			ra = model_regs[a[3:0]];
			rb = model_regs[b[3:0]];
			pc = pc + 8'd1;
			steps++;
			if (steps > 4000) begin
				stop_on_error("Reference model did not reach the end of the program");
			end
			case (op)
				cpu_pkg::OP_EOF: begin
					exp_done = 1'b1;
					halted = 1'b1;
				end
				cpu_pkg::OP_LOAD, cpu_pkg::OP_STORE: begin
					addr = (op == cpu_pkg::OP_LOAD) ? sp - {a, b} : sp - {b, c};
					if (addr > cpu_pkg::STACK_LIMIT) begin
						exp_fault = 1'b1;
						halted = 1'b1;
					end else if (op == cpu_pkg::OP_LOAD) begin
						model_regs[c[3:0]] = model_stack[addr];
					end else begin
						model_stack[addr] = ra;
					end
				end
				cpu_pkg::OP_LITERAL: model_regs[c[3:0]] = {a, b};
				cpu_pkg::OP_OUTPUT: exp_out.push_back(ra);
				cpu_pkg::OP_ADD: model_regs[c[3:0]] = ra + rb;
				cpu_pkg::OP_SUB: model_regs[c[3:0]] = ra - rb;
				cpu_pkg::OP_MUL: model_regs[c[3:0]] = cpu_pkg::word_t'(ra * rb);
				cpu_pkg::OP_BRANCH: if (ra == '0) pc = pc + 8'd1;
				cpu_pkg::OP_JUMP: pc = (a == '0) ? cpu_pkg::imem_addr_t'({b, c}) : rb[7:0];
				cpu_pkg::OP_STACK: sp = sp + {a, b};
				cpu_pkg::OP_INC: model_regs[a[3:0]] = ra + 16'd1;
				cpu_pkg::OP_DEC: model_regs[a[3:0]] = ra - 16'd1;
				cpu_pkg::OP_MOV: model_regs[b[3:0]] = ra;
				cpu_pkg::OP_NOT: model_regs[b[3:0]] = (ra == '0) ? 16'd1 : 16'd0;
				cpu_pkg::OP_OR: model_regs[c[3:0]] = (ra != '0 || rb != '0) ? 16'd1 : 16'd0;
				cpu_pkg::OP_AND: model_regs[c[3:0]] = (ra != '0 && rb != '0) ? 16'd1 : 16'd0;
				cpu_pkg::OP_EQ: model_regs[c[3:0]] = (ra == rb) ? 16'd1 : 16'd0;
				cpu_pkg::OP_LT: model_regs[c[3:0]] = ($signed(ra) < $signed(rb)) ? 16'd1 : 16'd0;
				cpu_pkg::OP_GT: model_regs[c[3:0]] = ($signed(ra) > $signed(rb)) ? 16'd1 : 16'd0;
				default: begin
					exp_unknown = 1'b1;
					halted = 1'b1;
				end
			endcase
		end
	endtask

	task automatic run_program(int mode);
		string name;
		int cycles;
		name = test_names[mode];
		gen_program(mode);
		run_model();
		@(negedge clock);
		reset_n = 1'b0;
		start = 1'b0;
		load_write = 1'b0;
		repeat (5) @(negedge clock);
		reset_n = 1'b1;
		compare_flag(name, "running after reset", 1'b0, running);
		compare_flag(name, "done after reset", 1'b0, done);
		compare_flag(name, "error after reset", 1'b0, error);
		compare_flag(name, "out_valid after reset", 1'b0, out_valid);
		compare_word(name, "out_value after reset", '0, out_value);
		for (int i = 0; i < cpu_pkg::IMEM_DEPTH; i++) begin
			@(negedge clock);
			load_write = 1'b1;
			load_address = cpu_pkg::imem_addr_t'(i);
			load_data = prog[i];
		end
		@(negedge clock);
		load_write = 1'b0;
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		act_out.delete();
		cycles = 0;
		while (!(done || error)) begin
			@(negedge clock);
			if (out_valid) act_out.push_back(out_value);
			cycles++;
			if (cycles > 5000) begin
				stop_on_error($sformatf("Timeout: %s program never raised done or error", name));
			end
		end
		repeat (4) begin  // Nothing may follow the halt
			@(negedge clock);
			if (out_valid) act_out.push_back(out_value);
		end
		compare_word(name, "output count", cpu_pkg::word_t'(exp_out.size()),
			cpu_pkg::word_t'(act_out.size()));
		foreach (exp_out[i]) begin
			compare_word(name, $sformatf("output %0d", i), exp_out[i], act_out[i]);
		end
		compare_flag(name, "done", exp_done, done);
		compare_flag(name, "unknown_opcode", exp_unknown, unknown_opcode);
		compare_flag(name, "stack_fault", exp_fault, stack_fault);
		compare_flag(name, "error", exp_unknown | exp_fault, error);
		compare_flag(name, "running", 1'b0, running);
	endtask

	initial begin
		reset_n = 1'b0;
		load_write = 1'b0;
		load_address = '0;
		load_data = '0;
		start = 1'b0;
		for (int n = 0; n < 15; n++) begin
			run_program(n % 5);
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== sources.f ====
verilog/cpu_pkg.sv
verilog/instruction_memory.sv
verilog/register_file.sv
verilog/alu.sv
verilog/stack_memory.sv
verilog/cpu_control.sv
verilog/playground_cpu.sv
verif/playground_cpu_chk.sv
verif/playground_cpu_tb.sv

// ==== Bender.yml ====
package:
  name: playground_cpu

sources:
  - files:
      - verilog/cpu_pkg.sv
      - verilog/instruction_memory.sv
      - verilog/register_file.sv
      - verilog/alu.sv
      - verilog/stack_memory.sv
      - verilog/cpu_control.sv
      - verilog/playground_cpu.sv
  - target: test
    files:
      - verif/playground_cpu_chk.sv
      - verif/playground_cpu_tb.sv
